// ==== sim/program.hex ====
// One 32-bit instruction word per line, word address 0 upward
24010001
24020002
00221821
8C240008
AC24000C
10220003
00642825
14600002
24030010
00000000
0800000C
00221821
0C000020
24040004
8C250010
1425FFF8
AC250014
00642825
24050005
FC210000
1000FFFF
00000000
8C260018
24060006
08000000
00A63021
14C0000A
AC26001C
0C00003F
24070007
00E73821
1007FFE0
8C270020
24080008
01084021
AC280024
15000004
0810000F
24090009
01294821
0E00ABCD
8C290028
1129FFF0
240A000A
014A5021
AC2A002C
15400008
00000000
0BFFFFFF
240B000B
8C2B0030
016B5821
116B8000
AC2B0034
240C000C
15807FFF
018C6021
0C000010
8C2C0038
240D000D
01AD6821
1000FFC2
AC2D003C
08000000

// ==== sim.f ====
design/cpu_pkg.sv
design/prefetch_stage.sv
design/inst_rom_port.sv
design/fetch_stage.sv
design/decode_stage.sv
design/frontend_top.sv
sim/frontend_chk.sv
sim/frontend_tb.sv

// ==== Bender.yml ====
package:
  name: frontend

sources:
  - design/cpu_pkg.sv
  - design/prefetch_stage.sv
  - design/inst_rom_port.sv
  - design/fetch_stage.sv
  - design/decode_stage.sv
  - design/frontend_top.sv
  - target: simulation
    files:
      - sim/frontend_chk.sv
      - sim/frontend_tb.sv

// ==== sim/frontend_tb.sv ====
`timescale 1ns/1ps

module frontend_tb
    import cpu_pkg::*;
();

    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 5;
    localparam int PAIR_CYCLES   = 8;   // Slow pair with stalls
    localparam int SEQ_PAIRS     = 36;  // Whole ROM plus a wrap
    localparam int NUM_REDIRECTS = 6;
    localparam int PAIRS_AFTER   = 3;
    localparam int MAX_GAP       = 15;
    localparam int STALL_CYCLES  = 12;
    localparam int ROUND_CYCLES  = MAX_GAP + 4 + PAIRS_AFTER * PAIR_CYCLES;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + SEQ_PAIRS * PAIR_CYCLES
                                  + 3 * NUM_REDIRECTS * ROUND_CYCLES
                                  + STALL_CYCLES + 4 * PAIR_CYCLES + 200;

    logic  clk;
    logic  reset;
    logic  redirect;
    pc_t   redirect_pc;
    logic  out_allowin;
    logic  out_valid;
    logic  d1_valid;
    logic  d2_valid;
    pc_t   d1_pc;
    pc_t   d2_pc;
    inst_t d1_inst;
    inst_t d2_inst;
    exc_t  d1_exc;
    exc_t  d2_exc;
    logic  d1_is_branch;
    logic  d2_is_branch;
    pc_t   d1_target;
    pc_t   d2_target;

    logic [15:0] lfsr_state;
    logic        force_stall;
    int          accept_count;
    int          test_count;
    int          err_before;
    int          pairs_before;

    frontend_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic pick_pc(input logic odd_word, input logic misalign, output pc_t pc);
        logic [31:0] hi;
        logic [31:0] idx;
        logic [31:0] lo;
        take_bits(2, hi);
        take_bits(6, idx);
        take_bits(2, lo);
        pc = {hi[1:0], 21'b0, idx[5:0], 3'b000};
        if (odd_word) begin
            pc[2] = 1'b1;
        end
        if (misalign) begin
            pc[1:0] = (lo[1:0] == 2'b00) ? 2'b01 : lo[1:0];
        end
    endtask

    // Bits drawn on the rising edge, test choices on the falling one
    always @(posedge clk) begin
        logic [31:0] r;
        take_bits(2, r);
        if (force_stall) begin
            out_allowin <= 1'b0;
        end else begin
            out_allowin <= (r[1:0] != 2'b00);  // Low about one cycle in four
        end
    end

    always @(negedge clk) begin
        if (!reset && out_valid && out_allowin && !redirect) begin
            accept_count++;   // Pair moves on the next edge
        end
    end

    task automatic send_redirect(input pc_t pc);
        @(posedge clk);
        redirect    <= 1'b1;
        redirect_pc <= pc;
        @(posedge clk);
        redirect    <= 1'b0;
    endtask

    task automatic wait_pairs(input int n);
        int target;
        target = accept_count + n;
        while (accept_count < target) begin
            @(posedge clk);
        end
    endtask

    task automatic redirect_round(input logic odd_word, input logic misalign, input int pairs);
        pc_t         pc;
        logic [31:0] gap;
        logic [31:0] odd;
        @(negedge clk);
        take_bits(4, gap);
        take_bits(1, odd);
        pick_pc(odd_word || (misalign && odd[0]), misalign, pc);
        repeat (gap[3:0]) @(posedge clk);
        send_redirect(pc);
        wait_pairs(pairs);
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = u_dut.u_chk.fail_count - err_before;
        test_count++;
        $display("[%0t] test %0d %s: %0d pairs, %0d errors",
                 $time, test_count, name, accept_count - pairs_before, errs);
        err_before   = u_dut.u_chk.fail_count;
        pairs_before = accept_count;
    endtask

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        pc_t pc;
        reset        = 1'b1;
        redirect     = 1'b0;
        redirect_pc  = '0;
        out_allowin  = 1'b0;
        force_stall  = 1'b0;
        lfsr_state   = 16'd7303;
        accept_count = 0;
        test_count   = 0;
        err_before   = 0;
        pairs_before = 0;

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        wait_pairs(SEQ_PAIRS);
        finish_test("sequential fetch after reset");

        for (int i = 0; i < NUM_REDIRECTS; i++) begin
            redirect_round(1'b0, 1'b0, PAIRS_AFTER);
        end
        finish_test("aligned redirects");

        for (int i = 0; i < NUM_REDIRECTS; i++) begin
            redirect_round(1'b1, 1'b0, PAIRS_AFTER);
        end
        finish_test("odd-word redirects");

        for (int i = 0; i < NUM_REDIRECTS; i++) begin
            redirect_round(1'b0, 1'b1, 1);   // Fetch parks after the ADEL pair
        end
        finish_test("misaligned redirects");

        @(negedge clk);
        force_stall = 1'b1;
        pick_pc(1'b0, 1'b0, pc);
        send_redirect(pc);
        repeat (STALL_CYCLES) @(posedge clk);
        @(negedge clk);
        force_stall = 1'b0;
        wait_pairs(4);
        finish_test("stall hold");

        repeat (2) @(posedge clk);
        $display("tests %0d, pairs %0d, errors %0d",
                 test_count, accept_count, u_dut.u_chk.fail_count);
        if (u_dut.u_chk.fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== sim/frontend_chk.sv ====
`timescale 1ns/1ps

module frontend_chk
    import cpu_pkg::*;
(
    input logic  clk,
    input logic  reset,
    input logic  redirect,
    input pc_t   redirect_pc,
    input logic  out_allowin,
    input logic  out_valid,
    input logic  d1_valid,
    input logic  d2_valid,
    input pc_t   d1_pc,
    input pc_t   d2_pc,
    input inst_t d1_inst,
    input inst_t d2_inst,
    input exc_t  d1_exc,
    input exc_t  d2_exc,
    input logic  d1_is_branch,
    input logic  d2_is_branch,
    input pc_t   d1_target,
    input pc_t   d2_target
);

    int     fail_count = 0;
    inst_t  rom_copy [ROM_WORDS];
    pc_t    exp_pc;      // Slot1 pc of the next pair
    logic   exp_slot1;
    logic   exp_adel;
    logic   accept;
    logic   chk1;
    logic   chk2;
    inst_t  word1;
    inst_t  word2;
    logic [70:0]  hold_ctl;
    logic [129:0] hold_data;

    initial begin
        $readmemh("sim/program.hex", rom_copy);
    end

    function automatic logic expect_branch(inst_t word);
        return word[31:26] inside {OP_BEQ, OP_BNE, OP_J, OP_JAL};
    endfunction

    function automatic pc_t expect_target(pc_t pc, inst_t word);
        pc_t seq;
        pc_t offset;
        seq    = pc + 32'd4;
        offset = {{16{word[15]}}, word[15:0]};
        if (word[31:26] inside {OP_J, OP_JAL}) begin
            return {seq[31:28], word[25:0], 2'b00};
        end
        return seq + (offset << 2);
    endfunction

    function automatic exc_t expect_exc(inst_t word);
        if (word[31:26] inside {OP_SPECIAL, OP_J, OP_JAL, OP_BEQ, OP_BNE,
                                OP_ADDIU, OP_LW, OP_SW}) begin
            return EXC_NONE;
        end
        return EXC_RI;
    endfunction

    assign accept = out_valid && out_allowin && !redirect;
    assign chk1   = out_valid && d1_valid && !exp_adel;
    assign chk2   = out_valid && d2_valid && !exp_adel;
    assign word1  = rom_copy[d1_pc[7:2]];
    assign word2  = rom_copy[d2_pc[7:2]];

    assign hold_ctl  = {out_valid, d1_valid, d2_valid, d1_pc, d2_pc, d1_exc, d2_exc};
    assign hold_data = {d1_inst, d2_inst, d1_is_branch, d2_is_branch, d1_target, d2_target};

    always_ff @(posedge clk) begin
        if (reset) begin
            exp_pc    <= RESET_PC;
            exp_slot1 <= 1'b1;
            exp_adel  <= 1'b0;
        end else if (redirect) begin
            exp_pc    <= {redirect_pc[31:3], 1'b0, redirect_pc[1:0]};
            exp_slot1 <= !redirect_pc[2];   // Odd-word target drops slot1
            exp_adel  <= redirect_pc[1:0] != 2'b00;
        end else if (accept) begin
            exp_pc    <= {d1_pc[31:3], 3'b000} + 32'd8;
            exp_slot1 <= 1'b1;
        end
    end

    a_reset_quiet: assert property (@(posedge clk)
        $fell(reset) |-> !out_valid [*(INST_LATENCY+2)])
        else begin fail_count++; $error("ERROR %0t: out_valid too early after reset", $time); end

    // ADEL pairs skip the ROM and may come sooner
    a_redirect_quiet: assert property (@(posedge clk) disable iff (reset)
        (redirect && redirect_pc[1:0] == 2'b00) |=> !out_valid [*(INST_LATENCY+2)])
        else begin fail_count++; $error("ERROR %0t: out_valid too early after redirect", $time); end

    a_pair_pc: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> (d1_pc == exp_pc) && (d2_pc == d1_pc + 32'd4))
        else begin fail_count++; $error("ERROR %0t: pair pc out of sequence", $time); end

    a_slot_valid: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> (d1_valid == exp_slot1) && d2_valid)
        else begin fail_count++; $error("ERROR %0t: wrong slot valid bits", $time); end

    a_inst1: assert property (@(posedge clk) disable iff (reset)
        chk1 |-> d1_inst == word1)
        else begin fail_count++; $error("ERROR %0t: slot1 instruction mismatch", $time); end

    a_inst2: assert property (@(posedge clk) disable iff (reset)
        chk2 |-> d2_inst == word2)
        else begin fail_count++; $error("ERROR %0t: slot2 instruction mismatch", $time); end

    a_dec1: assert property (@(posedge clk) disable iff (reset)
        chk1 |-> (d1_exc == expect_exc(word1)) && (d1_is_branch == expect_branch(word1)))
        else begin fail_count++; $error("ERROR %0t: slot1 exc or branch flag wrong", $time); end

    a_dec2: assert property (@(posedge clk) disable iff (reset)
        chk2 |-> (d2_exc == expect_exc(word2)) && (d2_is_branch == expect_branch(word2)))
        else begin fail_count++; $error("ERROR %0t: slot2 exc or branch flag wrong", $time); end

    a_target1: assert property (@(posedge clk) disable iff (reset)
        chk1 && expect_branch(word1) |-> d1_target == expect_target(d1_pc, word1))
        else begin fail_count++; $error("ERROR %0t: slot1 branch target wrong", $time); end

    a_target2: assert property (@(posedge clk) disable iff (reset)
        chk2 && expect_branch(word2) |-> d2_target == expect_target(d2_pc, word2))
        else begin fail_count++; $error("ERROR %0t: slot2 branch target wrong", $time); end

    a_adel: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> exp_adel == ((d1_exc == EXC_ADEL) && (d2_exc == EXC_ADEL)))
        else begin fail_count++; $error("ERROR %0t: address error marking wrong", $time); end

    a_hold_ctl: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_allowin && !redirect |=> $stable(hold_ctl))
        else begin fail_count++; $error("ERROR %0t: pair changed under stall", $time); end

    a_hold_data: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_allowin && !redirect |=> $stable(hold_data))
        else begin fail_count++; $error("ERROR %0t: decode data changed under stall", $time); end

endmodule

bind frontend_top frontend_chk u_chk (.*);

// ==== design/frontend_top.sv ====
`timescale 1ns/1ps

module frontend_top
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  redirect,
    input  pc_t   redirect_pc,
    input  logic  out_allowin,
    output logic  out_valid,
    output logic  d1_valid,
    output logic  d2_valid,
    output pc_t   d1_pc,
    output pc_t   d2_pc,
    output inst_t d1_inst,
    output inst_t d2_inst,
    output exc_t  d1_exc,
    output exc_t  d2_exc,
    output logic  d1_is_branch,
    output logic  d2_is_branch,
    output pc_t   d1_target,
    output pc_t   d2_target
);

    // ROM port
    logic  req;
    pc_t   req_pc;
    logic  addr_ok;
    logic  data_ok;
    inst_t data1;
    inst_t data2;

    // Prefetch to fetch
    logic  pfs_to_valid;
    logic  fs_allowin;
    logic  slot1_valid;
    logic  slot2_valid;
    pc_t   slot1_pc;
    pc_t   slot2_pc;
    exc_t  slot1_exc;
    exc_t  slot2_exc;

    // Fetch to decode
    logic  ds_allowin;
    logic  fs_to_valid;
    logic  fs1_valid;
    logic  fs2_valid;
    pc_t   fs1_pc;
    pc_t   fs2_pc;
    inst_t fs1_inst;
    inst_t fs2_inst;
    exc_t  fs1_exc;
    exc_t  fs2_exc;

    prefetch_stage u_prefetch (
        .clk          (clk),
        .reset        (reset),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .fs_allowin   (fs_allowin),
        .addr_ok      (addr_ok),
        .req          (req),
        .req_pc       (req_pc),
        .pfs_to_valid (pfs_to_valid),
        .slot1_valid  (slot1_valid),
        .slot2_valid  (slot2_valid),
        .slot1_pc     (slot1_pc),
        .slot2_pc     (slot2_pc),
        .slot1_exc    (slot1_exc),
        .slot2_exc    (slot2_exc)
    );

    inst_rom_port u_rom (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .req_pc  (req_pc),
        .addr_ok (addr_ok),
        .data_ok (data_ok),
        .data1   (data1),
        .data2   (data2)
    );

    fetch_stage u_fetch (
        .clk          (clk),
        .reset        (reset),
        .flush        (redirect),
        .pfs_to_valid (pfs_to_valid),
        .slot1_valid  (slot1_valid),
        .slot2_valid  (slot2_valid),
        .slot1_pc     (slot1_pc),
        .slot2_pc     (slot2_pc),
        .slot1_exc    (slot1_exc),
        .slot2_exc    (slot2_exc),
        .ds_allowin   (ds_allowin),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .data1        (data1),
        .data2        (data2),
        .fs_allowin   (fs_allowin),
        .fs_to_valid  (fs_to_valid),
        .fs1_valid    (fs1_valid),
        .fs2_valid    (fs2_valid),
        .fs1_pc       (fs1_pc),
        .fs2_pc       (fs2_pc),
        .fs1_inst     (fs1_inst),
        .fs2_inst     (fs2_inst),
        .fs1_exc      (fs1_exc),
        .fs2_exc      (fs2_exc)
    );

    decode_stage u_decode (
        .clk          (clk),
        .reset        (reset),
        .flush        (redirect),
        .fs_to_valid  (fs_to_valid),
        .fs1_valid    (fs1_valid),
        .fs2_valid    (fs2_valid),
        .fs1_pc       (fs1_pc),
        .fs2_pc       (fs2_pc),
        .fs1_inst     (fs1_inst),
        .fs2_inst     (fs2_inst),
        .fs1_exc      (fs1_exc),
        .fs2_exc      (fs2_exc),
        .out_allowin  (out_allowin),
        .ds_allowin   (ds_allowin),
        .out_valid    (out_valid),
        .d1_valid     (d1_valid),
        .d2_valid     (d2_valid),
        .d1_pc        (d1_pc),
        .d2_pc        (d2_pc),
        .d1_inst      (d1_inst),
        .d2_inst      (d2_inst),
        .d1_exc       (d1_exc),
        .d2_exc       (d2_exc),
        .d1_is_branch (d1_is_branch),
        .d2_is_branch (d2_is_branch),
        .d1_target    (d1_target),
        .d2_target    (d2_target)
    );

endmodule

// ==== design/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  flush,
    input  logic  fs_to_valid,
    input  logic  fs1_valid,
    input  logic  fs2_valid,
    input  pc_t   fs1_pc,
    input  pc_t   fs2_pc,
    input  inst_t fs1_inst,
    input  inst_t fs2_inst,
    input  exc_t  fs1_exc,
    input  exc_t  fs2_exc,
    input  logic  out_allowin,
    output logic  ds_allowin,
    output logic  out_valid,
    output logic  d1_valid,
    output logic  d2_valid,
    output pc_t   d1_pc,
    output pc_t   d2_pc,
    output inst_t d1_inst,
    output inst_t d2_inst,
    output exc_t  d1_exc,
    output exc_t  d2_exc,
    output logic  d1_is_branch,
    output logic  d2_is_branch,
    output pc_t   d1_target,
    output pc_t   d2_target
);

    logic load;

    function automatic logic is_branch_op(inst_t inst);
        opcode_t op;
        op = inst[31:26];
        return (op == OP_BEQ) || (op == OP_BNE) || (op == OP_J) || (op == OP_JAL);
    endfunction

    function automatic pc_t branch_target(pc_t pc, inst_t inst);
        opcode_t op;
        pc_t     seq_pc;
        op     = inst[31:26];
        seq_pc = pc + 32'd4;
        if ((op == OP_BEQ) || (op == OP_BNE)) begin
            return seq_pc + {{14{inst[15]}}, inst[15:0], 2'b00};
        end else if ((op == OP_J) || (op == OP_JAL)) begin
            return {seq_pc[31:28], inst[25:0], 2'b00};   // Region jump
        end
        return '0;
    endfunction

    // Address error wins over a reserved opcode
    function automatic exc_t mark_exc(exc_t exc, inst_t inst);
        if (exc == EXC_ADEL) begin
            return exc;
        end
        case (inst[31:26])
            OP_SPECIAL, OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_ADDIU, OP_LW, OP_SW: return exc;
            default: return EXC_RI;
        endcase
    endfunction

    assign ds_allowin = !out_valid || out_allowin;
    assign load       = fs_to_valid && ds_allowin;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            out_valid <= 1'b0;
        end else if (ds_allowin) begin
            out_valid <= fs_to_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            d1_valid     <= fs1_valid;
            d2_valid     <= fs2_valid;
            d1_pc        <= fs1_pc;
            d2_pc        <= fs2_pc;
            d1_inst      <= fs1_inst;
            d2_inst      <= fs2_inst;
            d1_exc       <= mark_exc(fs1_exc, fs1_inst);
            d2_exc       <= mark_exc(fs2_exc, fs2_inst);
            d1_is_branch <= is_branch_op(fs1_inst);
            d2_is_branch <= is_branch_op(fs2_inst);
            d1_target    <= branch_target(fs1_pc, fs1_inst);
            d2_target    <= branch_target(fs2_pc, fs2_inst);
        end
    end

endmodule

// ==== design/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  flush,
    input  logic  pfs_to_valid,
    input  logic  slot1_valid,
    input  logic  slot2_valid,
    input  pc_t   slot1_pc,
    input  pc_t   slot2_pc,
    input  exc_t  slot1_exc,
    input  exc_t  slot2_exc,
    input  logic  ds_allowin,
    input  logic  addr_ok,
    input  logic  data_ok,
    input  inst_t data1,
    input  inst_t data2,
    output logic  fs_allowin,
    output logic  fs_to_valid,
    output logic  fs1_valid,
    output logic  fs2_valid,
    output pc_t   fs1_pc,
    output pc_t   fs2_pc,
    output inst_t fs1_inst,
    output inst_t fs2_inst,
    output exc_t  fs1_exc,
    output exc_t  fs2_exc
);

    logic         q_valid [QUEUE_DEPTH];
    fetch_state_t q_state [QUEUE_DEPTH];
    pc_t          q_pc    [QUEUE_DEPTH];
    inst_t        q_inst  [QUEUE_DEPTH];
    exc_t         q_exc   [QUEUE_DEPTH];

    qidx_t   head;
    qidx_t   head_nx;
    qidx_t   tail;
    qidx_t   tail_nx;
    qidx_t   fill;       // Pair waiting on the ROM
    qidx_t   fill_nx;
    qcount_t count;
    logic    data_cancel;
    logic    inflight;
    logic    push;
    logic    pop;
    logic    fill_done;

    assign head_nx = head + qidx_t'(1);
    assign tail_nx = tail + qidx_t'(1);

    // Head may be complete and stalled, then the waiter is the next pair
    assign fill    = (q_state[head] == FETCH_WAIT) ? head : head + qidx_t'(2);
    assign fill_nx = fill + qidx_t'(1);

    assign fs_allowin  = count <= qcount_t'(QUEUE_DEPTH - 2);   // Room for a pair
    assign push        = pfs_to_valid && fs_allowin;
    assign fill_done   = data_ok && !data_cancel;
    assign fs_to_valid = (count != '0) && (q_state[head] == FETCH_COMPLETE);
    assign pop         = fs_to_valid && ds_allowin;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                q_valid[i] <= 1'b0;
                q_state[i] <= FETCH_WAIT;
            end
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                q_valid[tail]    <= slot1_valid;
                q_valid[tail_nx] <= slot2_valid;
                // Exception slots need no ROM data
                q_state[tail]    <= (slot1_exc != EXC_NONE) ? FETCH_COMPLETE : FETCH_WAIT;
                q_state[tail_nx] <= (slot2_exc != EXC_NONE) ? FETCH_COMPLETE : FETCH_WAIT;
                tail             <= tail + qidx_t'(2);
            end
            if (fill_done) begin
                q_state[fill]    <= FETCH_COMPLETE;
                q_state[fill_nx] <= FETCH_COMPLETE;
            end
            if (pop) begin
                q_valid[head]    <= 1'b0;
                q_valid[head_nx] <= 1'b0;
                head             <= head + qidx_t'(2);
            end
            case ({push, pop})
                2'b10:   count <= count + qcount_t'(2);
                2'b01:   count <= count - qcount_t'(2);
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            q_pc[tail]     <= slot1_pc;
            q_pc[tail_nx]  <= slot2_pc;
            q_exc[tail]    <= slot1_exc;
            q_exc[tail_nx] <= slot2_exc;
        end
        if (fill_done) begin
            q_inst[fill]    <= data1;
            q_inst[fill_nx] <= data2;
        end
    end

    // Response to a request issued before a flush is dropped
    always_ff @(posedge clk) begin
        if (reset) begin
            inflight    <= 1'b0;
            data_cancel <= 1'b0;
        end else begin
            if (addr_ok) begin
                inflight <= 1'b1;
            end else if (data_ok) begin
                inflight <= 1'b0;
            end
            if (flush && inflight && !data_ok) begin
                data_cancel <= 1'b1;
            end else if (data_ok) begin
                data_cancel <= 1'b0;
            end
        end
    end

    assign fs1_valid = q_valid[head] && (q_state[head] == FETCH_COMPLETE);
    assign fs2_valid = q_valid[head_nx] && (q_state[head_nx] == FETCH_COMPLETE);
    assign fs1_pc    = q_pc[head];
    assign fs2_pc    = q_pc[head_nx];
    assign fs1_inst  = q_inst[head];
    assign fs2_inst  = q_inst[head_nx];
    assign fs1_exc   = q_exc[head];
    assign fs2_exc   = q_exc[head_nx];

endmodule

// ==== design/inst_rom_port.sv ====
`timescale 1ns/1ps

module inst_rom_port
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  req,
    input  pc_t   req_pc,
    output logic  addr_ok,
    output logic  data_ok,
    output inst_t data1,
    output inst_t data2
);

    inst_t                   rom [ROM_WORDS];
    logic [INST_LATENCY-1:0] lat_sr;    // One bit per cycle in flight
    rom_idx_t                rd_idx;
    rom_idx_t                rd_idx_nx;

    initial begin
        $readmemh("sim/program.hex", rom);
    end

    // Single request in flight
    assign addr_ok = req && (lat_sr == '0);
    assign data_ok = lat_sr[INST_LATENCY-1];

    assign rd_idx_nx = rd_idx + rom_idx_t'(1);  // Wraps at the ROM end
    assign data1     = rom[rd_idx];
    assign data2     = rom[rd_idx_nx];

    always_ff @(posedge clk) begin
        if (reset) begin
            lat_sr <= '0;
        end else begin
            lat_sr <= {lat_sr[INST_LATENCY-2:0], addr_ok};
        end
    end

    always_ff @(posedge clk) begin
        if (addr_ok) begin
            rd_idx <= {req_pc[ROM_AW+1:3], 1'b0};  // Pair aligned
        end
    end

endmodule

// ==== design/prefetch_stage.sv ====
`timescale 1ns/1ps

module prefetch_stage
    import cpu_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic redirect,
    input  pc_t  redirect_pc,
    input  logic fs_allowin,
    input  logic addr_ok,
    output logic req,
    output pc_t  req_pc,
    output logic pfs_to_valid,
    output logic slot1_valid,
    output logic slot2_valid,
    output pc_t  slot1_pc,
    output pc_t  slot2_pc,
    output exc_t slot1_exc,
    output exc_t slot2_exc
);

    pc_t      fetch_pc;
    pc_t      pair_base;
    lat_cnt_t busy_cnt;     // Cycles left until the ROM answers
    logic     outstanding;
    logic     misaligned;
    logic     halted;       // Parked after an address error
    logic     adel_send;
    logic     accepted;

    assign pair_base   = {fetch_pc[31:3], 3'b000};
    assign misaligned  = fetch_pc[1:0] != 2'b00;
    assign outstanding = busy_cnt != '0;

    // Nothing issued in a redirect cycle
    assign req = fs_allowin && !outstanding && !misaligned && !halted && !redirect;
    assign req_pc   = pair_base;
    assign accepted = req && addr_ok;

    // Bad pc goes down as an exception pair, no ROM read
    assign adel_send = fs_allowin && misaligned && !halted && !redirect;

    assign pfs_to_valid = accepted || adel_send;

    assign slot1_valid = !fetch_pc[2];  // Odd-word start
    assign slot2_valid = 1'b1;
    assign slot1_pc    = pair_base | {30'b0, fetch_pc[1:0]};
    assign slot2_pc    = slot1_pc + 32'd4;
    assign slot1_exc   = misaligned ? EXC_ADEL : EXC_NONE;
    assign slot2_exc   = slot1_exc;

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_pc <= RESET_PC;
            halted   <= 1'b0;
        end else if (redirect) begin
            fetch_pc <= redirect_pc;
            halted   <= 1'b0;
        end else if (accepted) begin
            fetch_pc <= pair_base + 32'd8;
        end else if (adel_send) begin
            halted <= 1'b1;   // Wait for the next redirect
        end
    end

    // Keeps running through a redirect so the ROM drains first
    always_ff @(posedge clk) begin
        if (reset) begin
            busy_cnt <= '0;
        end else if (accepted) begin
            busy_cnt <= lat_cnt_t'(INST_LATENCY);
        end else if (outstanding) begin
            busy_cnt <= busy_cnt - lat_cnt_t'(1);
        end
    end

endmodule

// ==== design/cpu_pkg.sv ====
package cpu_pkg;

    typedef logic [31:0] pc_t;
    typedef logic [31:0] inst_t;
    typedef logic [1:0]  exc_t;
    typedef logic [5:0]  opcode_t;

    localparam exc_t EXC_NONE = 2'd0;
    localparam exc_t EXC_ADEL = 2'd1;  // Misaligned fetch address
    localparam exc_t EXC_RI   = 2'd2;  // Reserved instruction

    // State of one fetch queue slot
    typedef enum logic {
        FETCH_WAIT,
        FETCH_COMPLETE
    } fetch_state_t;

    localparam int  INST_LATENCY = 2;
    localparam int  ROM_WORDS    = 64;
    localparam int  ROM_AW       = $clog2(ROM_WORDS);
    localparam int  QUEUE_DEPTH  = 4;
    localparam pc_t RESET_PC     = 32'h0000_0000;

    typedef logic [ROM_AW-1:0]                rom_idx_t;
    typedef logic [$clog2(QUEUE_DEPTH)-1:0]   qidx_t;
    typedef logic [$clog2(QUEUE_DEPTH):0]     qcount_t;
    typedef logic [$clog2(INST_LATENCY+1)-1:0] lat_cnt_t;

    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_J       = 6'h02;
    localparam opcode_t OP_JAL     = 6'h03;
    localparam opcode_t OP_BEQ     = 6'h04;
    localparam opcode_t OP_BNE     = 6'h05;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_LW      = 6'h23;
    localparam opcode_t OP_SW      = 6'h2b;

endpackage
